//--- src.f
+incdir+test
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/instr_decoder.sv
hw/regfile.sv
hw/execute_stage.sv
hw/data_mem.sv
hw/hazard_unit.sv
hw/core_top.sv
test/tb_core.sv

//--- test/tb_iss_model.svh
// Reference model of the RV32I subset and a random program generator; loads and stores use words 0..7 from x0
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic word_t enc_r(logic [2:0] f3, logic [6:0] f7, reg_idx_t rd,
                                reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(opcode_e opc, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic word_t enc_j(reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic void put_instr(word_t instr);
    imem[wr_idx] = instr;
    wr_idx++;
endfunction

// Every program stops in a jump to itself, whose address marks the end of the run
function automatic void put_end_loop();
    loop_pc = word_t'(wr_idx) << 2;
    put_instr(enc_j(5'd0, 21'd0));
endfunction

// Executes one instruction on the model state and returns what should retire
function automatic retire_t ref_step(word_t instr);
    retire_t  ret;
    word_t    a;
    word_t    b;
    word_t    res;
    word_t    addr;
    word_t    next_pc;
    logic     writes;
    a       = ref_regs[instr[19:15]];
    b       = ref_regs[instr[24:20]];
    res     = '0;
    writes  = 1'b1;
    next_pc = ref_pc + 32'd4;
    case (instr[6:0])
        OPC_OP, OPC_OP_IMM: begin
            // Bit 5 of the opcode separates the register form from the immediate form
            if (!instr[5]) begin
                b = {{20{instr[31]}}, instr[31:20]};
            end
            case (instr[14:12])
                F3_SLT:  res = word_t'($signed(a) < $signed(b));
                F3_XOR:  res = a ^ b;
                F3_OR:   res = a | b;
                F3_AND:  res = a & b;
                default: res = (instr[5] && instr[30]) ? a - b : a + b;
            endcase
        end
        OPC_LOAD: begin
            addr = a + {{20{instr[31]}}, instr[31:20]};
            res  = ref_mem[addr[9:2]];
        end
        OPC_STORE: begin
            addr   = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            writes = 1'b0;
            ref_mem[addr[9:2]] = b;
        end
        OPC_BRANCH: begin
            writes = 1'b0;
            // funct3 bit 0 turns BEQ into BNE
            if ((a == b) != instr[12]) begin
                next_pc = ref_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
        end
        default: begin
            res     = ref_pc + 32'd4;
            next_pc = ref_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end
    endcase
    ret = '{pc: ref_pc, rd: '0, rd_we: 1'b0, wb_data: '0};
    if (writes && instr[11:7] != 5'd0) begin
        ret.rd               = instr[11:7];
        ret.rd_we            = 1'b1;
        ret.wb_data          = res;
        ref_regs[instr[11:7]] = res;
    end
    ref_pc = next_pc;
    return ret;
endfunction

// Random body over x0..x7 with forward branches and jumps that never pass the end loop
task automatic gen_random_program();
    logic [31:0] r;
    logic [2:0]  f3;
    int          off;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    // Zero the load window first, so no load reads an unwritten word
    for (int i = 0; i < 8; i++) begin
        put_instr(enc_s(5'd0, 5'd0, 12'(i * 4)));
    end
    for (int n = 0; n < PROG_LEN; n++) begin
        r   = next_rand();
        rd  = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3  = ALU_F3S[r[11:9] % 5];
        off = 1 + int'(r[13:12]) % ((PROG_LEN - n) < 3 ? (PROG_LEN - n) : 3);
        case (r[31:29])
            3'd0, 3'd1: begin
                put_instr(enc_r(f3, (f3 == F3_ADD_SUB && r[14]) ? FUNCT7_SUB : 7'd0,
                                rd, rs1, rs2));
            end
            3'd2, 3'd3: put_instr(enc_i(OPC_OP_IMM, f3, rd, rs1, r[26:15]));
            3'd4:       put_instr(enc_i(OPC_LOAD, F3_WORD, rd, 5'd0, {7'd0, r[14:12], 2'b00}));
            3'd5:       put_instr(enc_s(rs2, 5'd0, {7'd0, r[14:12], 2'b00}));
            3'd6:       put_instr(enc_b(r[14] ? F3_BNE : F3_BEQ, rs1, rs2, 13'(off * 4)));
            default:    put_instr(enc_j(rd, 21'(off * 4)));
        endcase
    end
    put_end_loop();
endtask

`endif

//--- test/tb_core.sv
// Programs must stay below byte 1024 and data memory keeps its words across resets
`timescale 1ns/1ps

module tb_core import rv_isa_pkg::*; import core_pkg::*; ();

    localparam word_t RESET_PC     = 32'h0000_0100;
    localparam int    DMEM_WORDS   = 256;
    localparam int    NUM_PROGS    = 6;
    localparam int    PROG_LEN     = 40;
    localparam int    DIRECTED_LEN = 19;
    localparam int    WATCHDOG_CYCLES = (DIRECTED_LEN + NUM_PROGS * (PROG_LEN + 9)) * 8 +
                                        (NUM_PROGS + 1) * 10 + 100;
    localparam logic [2:0] ALU_F3S [5] = '{F3_ADD_SUB, F3_SLT, F3_XOR, F3_OR, F3_AND};

    logic        clk;
    logic        rst_n_i;
    word_t       imem_data_i;
    word_t       imem_addr_o;
    logic        retire_valid_o;
    retire_t     retire_o;

    word_t       imem [256];
    word_t       ref_regs [32];
    word_t       dut_regs [32];
    word_t       ref_mem [DMEM_WORDS];
    word_t       ref_pc;
    word_t       loop_pc;
    int          wr_idx;
    logic        prog_done;
    int          fail_count;
    logic [31:0] rng_state;

    `include "tb_iss_model.svh"

    core_top #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .imem_data_i    (imem_data_i),
        .imem_addr_o    (imem_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    always #2 clk = ~clk;

    // Instruction memory answers the fetch address shortly after each edge
    always @(posedge clk) begin
        #1;
        imem_data_i = imem[imem_addr_o[9:2]];
    end

    task automatic stop_on_error(string line);
        fail_count++;
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_retire(retire_t got, retire_t exp);
        check_word("retire_o.pc", got.pc, exp.pc);
        check_word("retire_o.rd", word_t'(got.rd), word_t'(exp.rd));
        check_word("retire_o.rd_we", word_t'(got.rd_we), word_t'(exp.rd_we));
        check_word("retire_o.wb_data", got.wb_data, exp.wb_data);
    endtask

    // Unused slots hold their own byte address, which never decodes as a legal opcode
    task automatic start_reset();
        @(posedge clk);
        #1;
        rst_n_i   = 1'b0;
        ref_pc    = RESET_PC;
        prog_done = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
            dut_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = word_t'(i * 4);
        end
        wr_idx = RESET_PC[9:2];
    endtask

    task automatic finish_program();
        repeat (5) begin
            @(posedge clk);
            #1;
            if (retire_valid_o !== 1'b0) begin
                stop_on_error("retire_valid_o went high while reset was held");
            end
        end
        check_word("imem_addr_o", imem_addr_o, RESET_PC);
        rst_n_i = 1'b1;
        wait (prog_done);
    endtask

    // Forwarding, x0 writes, load-use, taken and not-taken branches and a JAL
    task automatic load_directed();
        put_instr(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, 12'd5));
        put_instr(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd2, 5'd1, 12'hffd));
        put_instr(enc_r(F3_ADD_SUB, 7'd0, 5'd3, 5'd1, 5'd2));
        put_instr(enc_r(F3_ADD_SUB, FUNCT7_SUB, 5'd4, 5'd3, 5'd1));
        put_instr(enc_r(F3_SLT, 7'd0, 5'd5, 5'd4, 5'd3));
        put_instr(enc_i(OPC_OP_IMM, F3_XOR, 5'd0, 5'd3, 12'd7));
        put_instr(enc_s(5'd3, 5'd0, 12'd8));
        put_instr(enc_s(5'd4, 5'd0, 12'd12));
        put_instr(enc_i(OPC_LOAD, F3_WORD, 5'd6, 5'd0, 12'd8));
        put_instr(enc_r(F3_ADD_SUB, 7'd0, 5'd7, 5'd6, 5'd6));
        put_instr(enc_i(OPC_LOAD, F3_WORD, 5'd1, 5'd0, 12'd12));
        put_instr(enc_b(F3_BEQ, 5'd1, 5'd4, 13'd8));
        put_instr(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, 12'd99));
        put_instr(enc_b(F3_BNE, 5'd1, 5'd4, 13'd8));
        put_instr(enc_j(5'd5, 21'd8));
        put_instr(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5'd3, 5'd0, 12'd77));
        put_instr(enc_i(OPC_OP_IMM, F3_OR, 5'd6, 5'd5, 12'h100));
        put_instr(enc_r(F3_AND, 7'd0, 5'd7, 5'd6, 5'd5));
        put_end_loop();
    endtask

    // Register file after the directed program, worked out by hand from its listing
    task automatic check_directed_regs();
        word_t exp_regs [32];
        word_t link;
        link = RESET_PC + 32'h3c;
        for (int i = 0; i < 32; i++) begin
            exp_regs[i] = '0;
        end
        // x2 and x3 keep their values because the skipped instructions never retire
        exp_regs[1] = 32'd2;
        exp_regs[2] = 32'd2;
        exp_regs[3] = 32'd7;
        exp_regs[4] = 32'd2;
        exp_regs[5] = link;
        exp_regs[6] = link | 32'h100;
        exp_regs[7] = exp_regs[6] & link;
        for (int i = 1; i < 32; i++) begin
            check_word($sformatf("x%0d", i), dut_regs[i], exp_regs[i]);
        end
    endtask

    // Every retirement is replayed on the model in program order
    always @(negedge clk) begin : compare_retire
        retire_t exp;
        if (rst_n_i && retire_valid_o) begin
            exp = ref_step(imem[ref_pc[9:2]]);
            check_retire(retire_o, exp);
            if (retire_o.rd_we) begin
                dut_regs[retire_o.rd] = retire_o.wb_data;
            end
            if (exp.pc == loop_pc) begin
                prog_done = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("Timeout: retirement stalled before all programs reached their end loop");
    end

    initial begin : main_sequence
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        imem_data_i = NOP_INSTR;
        fail_count  = 0;
        rng_state   = 32'h5aba;
        loop_pc     = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        start_reset();
        load_directed();
        finish_program();
        check_directed_regs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            start_reset();
            gen_random_program();
            finish_program();
        end
        if (fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- hw/core_top.sv
// Instruction memory is external with a combinational read of imem_addr_o, a byte address
`timescale 1ns/1ps

module core_top import rv_isa_pkg::*; import core_pkg::*; #(
    parameter word_t RESET_PC   = 32'h0000_0000,
    parameter int    DMEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  word_t   imem_data_i,
    output word_t   imem_addr_o,
    output logic    retire_valid_o,
    output retire_t retire_o
);

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    word_t    pc_q;
    word_t    pc_d;
    word_t    jal_target;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    ctrl_t    dec_ctrl;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;
    logic     dec_valid;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    dmem_rdata;
    logic     id_jal;
    logic     branch_taken;
    word_t    branch_target;
    logic     stall;
    logic     flush_id;
    logic     flush_ex;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    // Fetch always assumes not taken; execute and issue redirect it
    always_comb begin
        if (branch_taken) begin
            pc_d = branch_target;
        end else if (id_jal) begin
            pc_d = jal_target;
        end else if (stall) begin
            pc_d = pc_q;
        end else begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_id) begin
            if_id_q <= '{valid: 1'b0, pc: '0, instr: NOP_INSTR};
        end else if (!stall) begin
            if_id_q <= '{valid: 1'b1, pc: pc_q, instr: imem_data_i};
        end
    end

    instr_decoder u_decoder (
        .instr_i (if_id_q.instr),
        .ctrl_o  (dec_ctrl),
        .rs1_o   (dec_rs1),
        .rs2_o   (dec_rs2),
        .rd_o    (dec_rd),
        .imm_o   (dec_imm),
        .valid_o (dec_valid)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (mem_wb_q.rf_we),
        .waddr_i  (mem_wb_q.rd),
        .raddr1_i (dec_rs1),
        .raddr2_i (dec_rs2),
        .wdata_i  (mem_wb_q.wb_data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // JAL needs no register operand, so its target is ready in issue
    assign id_jal     = if_id_q.valid & dec_ctrl.is_jal;
    assign jal_target = if_id_q.pc + dec_imm;

    assign id_ex_d = '{
        valid:    if_id_q.valid & dec_valid,
        pc:       if_id_q.pc,
        ctrl:     if_id_q.valid ? dec_ctrl : '0,
        rs1:      dec_rs1,
        rs2:      dec_rs2,
        rd:       dec_rd,
        rs1_data: rf_rdata1,
        rs2_data: rf_rdata2,
        imm:      dec_imm
    };

    // A stall leaves a bubble behind the load, a taken branch kills the issuing instruction
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_ex || stall) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.ctrl  <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    execute_stage u_execute (
        .id_ex_i         (id_ex_q),
        .fwd_a_i         (fwd_a),
        .fwd_b_i         (fwd_b),
        .mem_fwd_i       (ex_mem_q.alu_res),
        .wb_fwd_i        (mem_wb_q.wb_data),
        .ex_mem_o        (ex_mem_d),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_q.valid <= 1'b0;
            ex_mem_q.ctrl  <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk     (clk),
        .we_i    (ex_mem_q.valid & ex_mem_q.ctrl.mem_wr),
        .addr_i  (ex_mem_q.alu_res),
        .wdata_i (ex_mem_q.store_data),
        .rdata_o (dmem_rdata)
    );

    // Stores and branches carry zero so retirement shows no stale data
    always_comb begin
        mem_wb_d = '{
            valid:   ex_mem_q.valid,
            pc:      ex_mem_q.pc,
            rd:      ex_mem_q.rd,
            rf_we:   ex_mem_q.valid & ex_mem_q.ctrl.rf_we,
            wb_data: '0
        };
        if (ex_mem_q.ctrl.rf_we) begin
            mem_wb_d.wb_data = ex_mem_q.ctrl.mem_rd ? dmem_rdata : ex_mem_q.alu_res;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wb_q.valid <= 1'b0;
            mem_wb_q.rf_we <= 1'b0;
        end else begin
            mem_wb_q <= mem_wb_d;
        end
    end

    hazard_unit u_hazard (
        .id_rs1_i       (dec_rs1),
        .id_rs2_i       (dec_rs2),
        .ex_rs1_i       (id_ex_q.rs1),
        .ex_rs2_i       (id_ex_q.rs2),
        .ex_rd_i        (id_ex_q.rd),
        .mem_rd_i       (ex_mem_q.rd),
        .wb_rd_i        (mem_wb_q.rd),
        .ex_mem_rd_i    (id_ex_q.valid & id_ex_q.ctrl.mem_rd),
        .mem_we_i       (ex_mem_q.valid & ex_mem_q.ctrl.rf_we),
        .wb_we_i        (mem_wb_q.rf_we),
        .id_jal_i       (id_jal),
        .branch_taken_i (branch_taken),
        .stall_o        (stall),
        .flush_id_o     (flush_id),
        .flush_ex_o     (flush_ex),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b)
    );

    assign retire_valid_o = mem_wb_q.valid;
    assign retire_o = '{
        pc:      mem_wb_q.pc,
        rd:      mem_wb_q.rd,
        rd_we:   mem_wb_q.rf_we,
        wb_data: mem_wb_q.wb_data
    };

endmodule

//--- hw/hazard_unit.sv
// Handles only the hazards of this pipeline: forwarding, one load-use bubble and control flushes
`timescale 1ns/1ps

module hazard_unit import rv_isa_pkg::*; import core_pkg::*; (
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,
    input  reg_idx_t ex_rs1_i,
    input  reg_idx_t ex_rs2_i,
    input  reg_idx_t ex_rd_i,
    input  reg_idx_t mem_rd_i,
    input  reg_idx_t wb_rd_i,
    input  logic     ex_mem_rd_i,
    input  logic     mem_we_i,
    input  logic     wb_we_i,
    input  logic     id_jal_i,
    input  logic     branch_taken_i,
    output logic     stall_o,
    output logic     flush_id_o,
    output logic     flush_ex_o,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o
);

    logic load_use;

    // The memory stage holds the younger result, so it wins over writeback
    function automatic fwd_sel_e pick_src(reg_idx_t src, reg_idx_t mem_rd, logic mem_we,
                                          reg_idx_t wb_rd, logic wb_we);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_we && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_we && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a_o = pick_src(ex_rs1_i, mem_rd_i, mem_we_i, wb_rd_i, wb_we_i);
    assign fwd_b_o = pick_src(ex_rs2_i, mem_rd_i, mem_we_i, wb_rd_i, wb_we_i);

    // Load data only exists after the memory stage, one cycle too late for execute
    assign load_use = ex_mem_rd_i && (ex_rd_i != '0) &&
                      ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

    // A taken branch discards the stalled instruction anyway
    assign stall_o    = load_use & ~branch_taken_i;
    assign flush_id_o = id_jal_i | branch_taken_i;
    assign flush_ex_o = branch_taken_i;

endmodule

//--- hw/data_mem.sv
// Word-only memory; DMEM_WORDS must be a power of two and higher addresses wrap around
`timescale 1ns/1ps

module data_mem import rv_isa_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  we_i,
    input  word_t addr_i,
    input  word_t wdata_i,
    output word_t rdata_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    typedef logic [AW-1:0] dmem_idx_t;

    word_t     mem [DMEM_WORDS];
    dmem_idx_t word_idx;

    // Byte offset bits are dropped, accesses are always whole words
    assign word_idx = addr_i[AW+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[word_idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[word_idx];

endmodule

//--- hw/execute_stage.sv
// Purely combinational; branches compare the forwarded operands and only BEQ and BNE exist
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*; import core_pkg::*; (
    input  id_ex_t   id_ex_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  word_t    mem_fwd_i,
    input  word_t    wb_fwd_i,
    output ex_mem_t  ex_mem_o,
    output logic     branch_taken_o,
    output word_t    branch_target_o
);

    word_t src_a;
    word_t src_b;
    word_t op_a;
    word_t op_b;
    word_t alu_res;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val,
                                      word_t mem_val, word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a_i, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign src_b = fwd_mux(fwd_b_i, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);

    // JAL borrows the adder to form its link value pc+4
    assign op_a = id_ex_i.ctrl.is_jal ? id_ex_i.pc : src_a;
    always_comb begin
        if (id_ex_i.ctrl.is_jal) begin
            op_b = 32'd4;
        end else if (id_ex_i.ctrl.use_imm) begin
            op_b = id_ex_i.imm;
        end else begin
            op_b = src_b;
        end
    end

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // BNE simply inverts the equality test of BEQ
    assign branch_taken_o  = id_ex_i.valid & id_ex_i.ctrl.is_branch &
                             ((src_a == src_b) ^ id_ex_i.ctrl.branch_ne);
    assign branch_target_o = id_ex_i.pc + id_ex_i.imm;

    assign ex_mem_o = '{
        valid:      id_ex_i.valid,
        pc:         id_ex_i.pc,
        ctrl:       id_ex_i.ctrl,
        rd:         id_ex_i.rd,
        alu_res:    alu_res,
        store_data: src_b
    };

endmodule

//--- hw/regfile.sv
// Reads are combinational and see a same-cycle write; x0 is hard-wired to zero
`timescale 1ns/1ps

module regfile import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs_q [32];

    // Bypasses the write port so issue sees the value leaving writeback
    function automatic word_t read_port(reg_idx_t raddr, word_t stored, logic we,
                                        reg_idx_t waddr, word_t wdata);
        if (raddr == '0) begin
            return '0;
        end
        if (we && waddr == raddr) begin
            return wdata;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(raddr1_i, regs_q[raddr1_i], we_i, waddr_i, wdata_i);
    assign rdata2_o = read_port(raddr2_i, regs_q[raddr2_i], we_i, waddr_i, wdata_i);

endmodule

//--- hw/instr_decoder.sv
// Decodes the RV32I subset only; rd and unused source indices come out as x0 when not needed
`timescale 1ns/1ps

module instr_decoder import rv_isa_pkg::*; import core_pkg::*; (
    input  word_t    instr_i,
    output ctrl_t    ctrl_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output word_t    imm_o,
    output logic     valid_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    logic       legal;
    ctrl_t      ctrl;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        ctrl      = '0;
        imm_o     = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        legal     = 1'b1;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                case (funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    legal = 1'b0;
                endcase
                if (opcode == OPC_OP) begin
                    uses_rs2 = 1'b1;
                    // Only SUB may set funct7, every other register op needs it clear
                    if (funct7 == FUNCT7_SUB && funct3 == F3_ADD_SUB) begin
                        ctrl.alu_op = ALU_SUB;
                    end else if (funct7 != 7'b0) begin
                        legal = 1'b0;
                    end
                end else begin
                    ctrl.use_imm = 1'b1;
                    imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};
                end
            end
            OPC_LOAD: begin
                uses_rs1     = 1'b1;
                writes_rd    = 1'b1;
                ctrl.mem_rd  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};
                legal        = (funct3 == F3_WORD);
            end
            OPC_STORE: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                ctrl.mem_wr  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm_o        = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                legal        = (funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (funct3 == F3_BNE);
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
                legal = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                writes_rd   = 1'b1;
                ctrl.is_jal = 1'b1;
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    assign valid_o = legal;
    assign rs1_o   = (legal && uses_rs1) ? instr_i[19:15] : '0;
    assign rs2_o   = (legal && uses_rs2) ? instr_i[24:20] : '0;
    assign rd_o    = (legal && writes_rd) ? instr_i[11:7] : '0;

    // A write to x0 is dropped here so later stages never see it
    always_comb begin
        ctrl_o = '0;
        if (legal) begin
            ctrl_o       = ctrl;
            ctrl_o.rf_we = (rd_o != '0);
        end
    end

endmodule

//--- hw/core_pkg.sv
// Pipeline-internal types; field order of the stage records is private to the core except retire_t
package core_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // Decoded control; an all-zero value is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    mem_rd;
        logic    mem_wr;
        logic    rf_we;
        logic    is_branch;
        logic    is_jal;
        logic    branch_ne;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_res;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rf_we;
        word_t    wb_data;
    } mem_wb_t;

    // One record per instruction leaving writeback
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     rd_we;
        word_t    wb_data;
    } retire_t;

endpackage

//--- hw/rv_isa_pkg.sv
// Encodings cover only the RV32I subset this core runs; every other encoding is treated as illegal
package rv_isa_pkg;

    // Architectural data and address word
    typedef logic [31:0] word_t;

    // Index into the 32-entry integer register file
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported instruction groups
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU group, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // Width field of LW and SW; only full words are supported
    localparam logic [2:0] F3_WORD    = 3'b010;

    // Selects SUB over ADD in the register form
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage
